/* hdl/aim_pkg.sv */
package aim_pkg;

    // one color channel, three per pixel
    localparam int BITS = 8;

    typedef struct packed {
        logic [BITS-1:0] r;
        logic [BITS-1:0] g;
        logic [BITS-1:0] b;
    } pixel_t;

    //////////////////////////////////////////////////////////////////////
    // raster timing, each axis runs active, front porch, sync, back porch
    //////////////////////////////////////////////////////////////////////

    // horizontal, in pixels
    localparam int H_ACT   = 16;
    localparam int H_FP    = 2;
    localparam int H_SYNC  = 2;
    localparam int H_BP    = 3;
    localparam int H_TOTAL = H_ACT + H_FP + H_SYNC + H_BP;

    // vertical, in lines
    localparam int V_ACT   = 8;
    localparam int V_FP    = 1;
    localparam int V_SYNC  = 1;
    localparam int V_BP    = 2;
    localparam int V_TOTAL = V_ACT + V_FP + V_SYNC + V_BP;

    localparam int H_CNT_W = 5;
    localparam int V_CNT_W = 4;

    // box overlay
    localparam int N_BOX     = 4;
    localparam int BOX_IDX_W = 2;

    // pixel fifo, source starts with FIFO_DEPTH credits
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = 3;

endpackage : aim_pkg

/* hdl/raster_counter.sv */
`timescale 1ns/10ps

module raster_counter (
    input  logic                        pix_clk,
    input  logic                        i_arst_n,
    output logic [aim_pkg::H_CNT_W-1:0] o_h_pos,
    output logic [aim_pkg::V_CNT_W-1:0] o_v_pos,
    output logic                        o_line_end
);

    import aim_pkg::*;

    logic frame_end;

    // last position of the line and of the frame
    assign o_line_end = (o_h_pos == H_CNT_W'(H_TOTAL - 1));
    assign frame_end  = o_line_end && (o_v_pos == V_CNT_W'(V_TOTAL - 1));

    always_ff @(posedge pix_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_h_pos <= '0;
        end else if (o_line_end) begin
            o_h_pos <= '0;
        end else begin
            o_h_pos <= o_h_pos + 1'b1;
        end
    end

    // line counter steps once per line
    always_ff @(posedge pix_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_v_pos <= '0;
        end else if (frame_end) begin
            o_v_pos <= '0;
        end else if (o_line_end) begin
            o_v_pos <= o_v_pos + 1'b1;
        end
    end

    a_pos_in_range: assert property (
        @(posedge pix_clk) disable iff (!i_arst_n)
        (o_h_pos < H_CNT_W'(H_TOTAL)) && (o_v_pos < V_CNT_W'(V_TOTAL))
    );

endmodule : raster_counter

/* hdl/video_timing_fsm.sv */
`timescale 1ns/10ps

module video_timing_fsm (
    input  logic                        pix_clk,
    input  logic                        i_arst_n,
    input  logic [aim_pkg::H_CNT_W-1:0] i_h_pos,
    input  logic [aim_pkg::V_CNT_W-1:0] i_v_pos,
    input  logic                        i_line_end,
    output logic                        o_pop,
    output logic                        o_de,
    output logic                        o_hsync,
    output logic                        o_vsync,
    output logic                        o_frame_start,
    output logic [aim_pkg::H_CNT_W-1:0] o_h_pos,
    output logic [aim_pkg::V_CNT_W-1:0] o_v_pos
);

    import aim_pkg::*;

    typedef enum logic [1:0] {
        ST_ACT,
        ST_FP,
        ST_SYNC,
        ST_BP
    } v_state_t;

    v_state_t v_state;
    v_state_t v_next;
    logic     h_act;
    logic     h_sync;
    logic     de_q;

    //////////////////////////////////////////////////////////////////////
    // horizontal phase straight from the position
    //////////////////////////////////////////////////////////////////////

    assign h_act  = (i_h_pos < H_CNT_W'(H_ACT));
    assign h_sync = (i_h_pos >= H_CNT_W'(H_ACT + H_FP)) &&
                    (i_h_pos <  H_CNT_W'(H_ACT + H_FP + H_SYNC));

    // vertical phase moves on the last pixel of a phase's last line
    always_comb begin
        v_next = v_state;
        if (i_line_end) begin
            case (v_state)
                ST_ACT:
                    if (i_v_pos == V_CNT_W'(V_ACT - 1)) v_next = ST_FP;
                ST_FP:
                    if (i_v_pos == V_CNT_W'(V_ACT + V_FP - 1)) v_next = ST_SYNC;
                ST_SYNC:
                    if (i_v_pos == V_CNT_W'(V_ACT + V_FP + V_SYNC - 1)) v_next = ST_BP;
                default:
                    if (i_v_pos == V_CNT_W'(V_TOTAL - 1)) v_next = ST_ACT;
            endcase
        end
    end

    always_ff @(posedge pix_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            v_state       <= ST_ACT;
            de_q          <= 1'b0;
            o_hsync       <= 1'b0;
            o_vsync       <= 1'b0;
            o_frame_start <= 1'b0;
        end else begin
            v_state       <= v_next;
            de_q          <= h_act && (v_state == ST_ACT);
            o_hsync       <= h_sync;
            o_vsync       <= (v_state == ST_SYNC);
            // first cycle of vertical sync
            o_frame_start <= (v_state == ST_SYNC) && (i_h_pos == '0) &&
                             (i_v_pos == V_CNT_W'(V_ACT + V_FP));
        end
    end

    // position follows the registered controls
    always_ff @(posedge pix_clk) begin
        o_h_pos <= i_h_pos;
        o_v_pos <= i_v_pos;
    end

    assign o_de  = de_q;
    assign o_pop = de_q;

    a_v_on_line_end: assert property (
        @(posedge pix_clk) disable iff (!i_arst_n)
        $changed(v_state) |-> $past(i_line_end)
    );

endmodule : video_timing_fsm

/* hdl/pixel_fifo.sv */
`timescale 1ns/10ps

module pixel_fifo (
    input  logic            pix_clk,
    input  logic            i_arst_n,
    input  logic            i_push,
    input  aim_pkg::pixel_t i_push_data,
    input  logic            i_pop,
    output aim_pkg::pixel_t o_pop_data,
    output logic            o_credit,
    output logic            o_underrun
);

    import aim_pkg::*;

    pixel_t                mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic                  empty;
    logic                  pop_ok;

    assign empty  = (count == '0);
    assign pop_ok = i_pop && !empty;

    always_ff @(posedge pix_clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    // empty pop shows black
    always_ff @(posedge pix_clk) begin
        if (pop_ok) begin
            o_pop_data <= mem[rd_ptr];
        end else if (i_pop) begin
            o_pop_data <= '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // pointers, occupancy, credit and sticky underrun
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge pix_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            o_credit   <= 1'b0;
            o_underrun <= 1'b0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_push, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit per pixel actually read
            o_credit <= pop_ok;
            if (i_pop && empty) begin
                o_underrun <= 1'b1;
            end
        end
    end

    // source must hold a credit for every push
    a_no_overflow: assert property (
        @(posedge pix_clk) disable iff (!i_arst_n)
        i_push |-> (count != (FIFO_PTR_W + 1)'(FIFO_DEPTH))
    );

endmodule : pixel_fifo

/* hdl/box_regs.sv */
`timescale 1ns/10ps

module box_regs (
    input  logic                                            pix_clk,
    input  logic                                            i_arst_n,
    input  logic                                            i_box_wr,
    input  logic [aim_pkg::BOX_IDX_W-1:0]                   i_box_idx,
    input  logic                                            i_box_en,
    input  logic [aim_pkg::H_CNT_W-1:0]                     i_box_x0,
    input  logic [aim_pkg::V_CNT_W-1:0]                     i_box_y0,
    input  logic [aim_pkg::H_CNT_W-1:0]                     i_box_x1,
    input  logic [aim_pkg::V_CNT_W-1:0]                     i_box_y1,
    input  aim_pkg::pixel_t                                 i_box_color,
    input  logic                                            i_frame_start,
    output logic [aim_pkg::N_BOX-1:0]                       o_box_en,
    output logic [aim_pkg::N_BOX-1:0][aim_pkg::H_CNT_W-1:0] o_box_x0,
    output logic [aim_pkg::N_BOX-1:0][aim_pkg::V_CNT_W-1:0] o_box_y0,
    output logic [aim_pkg::N_BOX-1:0][aim_pkg::H_CNT_W-1:0] o_box_x1,
    output logic [aim_pkg::N_BOX-1:0][aim_pkg::V_CNT_W-1:0] o_box_y1,
    output aim_pkg::pixel_t [aim_pkg::N_BOX-1:0]            o_box_color
);

    import aim_pkg::*;

    // shadow set, written at any time
    logic [N_BOX-1:0]              sh_en;
    logic [N_BOX-1:0][H_CNT_W-1:0] sh_x0;
    logic [N_BOX-1:0][V_CNT_W-1:0] sh_y0;
    logic [N_BOX-1:0][H_CNT_W-1:0] sh_x1;
    logic [N_BOX-1:0][V_CNT_W-1:0] sh_y1;
    pixel_t [N_BOX-1:0]            sh_color;

    always_ff @(posedge pix_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            sh_en    <= '0;
            o_box_en <= '0;
        end else begin
            if (i_box_wr) begin
                sh_en[i_box_idx] <= i_box_en;
            end
            if (i_frame_start) begin
                o_box_en <= sh_en;
            end
        end
    end

    // whole set commits together, never a mix of frames
    always_ff @(posedge pix_clk) begin
        if (i_box_wr) begin
            sh_x0[i_box_idx]    <= i_box_x0;
            sh_y0[i_box_idx]    <= i_box_y0;
            sh_x1[i_box_idx]    <= i_box_x1;
            sh_y1[i_box_idx]    <= i_box_y1;
            sh_color[i_box_idx] <= i_box_color;
        end
        if (i_frame_start) begin
            o_box_x0    <= sh_x0;
            o_box_y0    <= sh_y0;
            o_box_x1    <= sh_x1;
            o_box_y1    <= sh_y1;
            o_box_color <= sh_color;
        end
    end

endmodule : box_regs

/* hdl/box_overlay.sv */
`timescale 1ns/10ps

module box_overlay (
    input  logic                                            pix_clk,
    input  logic                                            i_arst_n,
    input  logic                                            i_de,
    input  logic                                            i_hsync,
    input  logic                                            i_vsync,
    input  logic [aim_pkg::H_CNT_W-1:0]                     i_h_pos,
    input  logic [aim_pkg::V_CNT_W-1:0]                     i_v_pos,
    input  aim_pkg::pixel_t                                 i_pix,
    input  logic [aim_pkg::N_BOX-1:0]                       i_box_en,
    input  logic [aim_pkg::N_BOX-1:0][aim_pkg::H_CNT_W-1:0] i_box_x0,
    input  logic [aim_pkg::N_BOX-1:0][aim_pkg::V_CNT_W-1:0] i_box_y0,
    input  logic [aim_pkg::N_BOX-1:0][aim_pkg::H_CNT_W-1:0] i_box_x1,
    input  logic [aim_pkg::N_BOX-1:0][aim_pkg::V_CNT_W-1:0] i_box_y1,
    input  aim_pkg::pixel_t [aim_pkg::N_BOX-1:0]            i_box_color,
    output logic                                            o_de,
    output logic                                            o_hsync,
    output logic                                            o_vsync,
    output aim_pkg::pixel_t                                 o_rgb
);

    import aim_pkg::*;

    logic [N_BOX-1:0] on_box;
    logic             hit;
    pixel_t           hit_color;
    logic             de_d;
    logic             hs_d;
    logic             vs_d;
    logic             hit_d;
    pixel_t           hit_color_d;

    //////////////////////////////////////////////////////////////////////
    // border hit test, one per box
    //////////////////////////////////////////////////////////////////////

    for (genvar b = 0; b < N_BOX; b++) begin : g_box
        logic in_x;
        logic in_y;
        logic on_edge;

        assign in_x    = (i_h_pos >= i_box_x0[b]) && (i_h_pos <= i_box_x1[b]);
        assign in_y    = (i_v_pos >= i_box_y0[b]) && (i_v_pos <= i_box_y1[b]);
        assign on_edge = (i_h_pos == i_box_x0[b]) || (i_h_pos == i_box_x1[b]) ||
                         (i_v_pos == i_box_y0[b]) || (i_v_pos == i_box_y1[b]);
        assign on_box[b] = i_box_en[b] && in_x && in_y && on_edge;
    end

    // lowest index wins
    always_comb begin
        hit       = 1'b0;
        hit_color = '0;
        for (int b = N_BOX - 1; b >= 0; b--) begin
            if (on_box[b]) begin
                hit       = 1'b1;
                hit_color = i_box_color[b];
            end
        end
    end

    // stage one lines up with fifo read data
    always_ff @(posedge pix_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            de_d  <= 1'b0;
            hs_d  <= 1'b0;
            vs_d  <= 1'b0;
            hit_d <= 1'b0;
        end else begin
            de_d  <= i_de;
            hs_d  <= i_hsync;
            vs_d  <= i_vsync;
            hit_d <= hit;
        end
    end

    always_ff @(posedge pix_clk) begin
        hit_color_d <= hit_color;
    end

    // output stage, black outside the active area
    always_ff @(posedge pix_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_de    <= 1'b0;
            o_hsync <= 1'b0;
            o_vsync <= 1'b0;
            o_rgb   <= '0;
        end else begin
            o_de    <= de_d;
            o_hsync <= hs_d;
            o_vsync <= vs_d;
            if (!de_d) begin
                o_rgb <= '0;
            end else if (hit_d) begin
                o_rgb <= hit_color_d;
            end else begin
                o_rgb <= i_pix;
            end
        end
    end

endmodule : box_overlay

/* hdl/aim_overlay_top.sv */
`timescale 1ns/10ps

module aim_overlay_top (
    input  logic                          pix_clk,
    input  logic                          i_arst_n,
    input  logic                          i_pix_valid,
    input  aim_pkg::pixel_t               i_pix_data,
    output logic                          o_credit,
    input  logic                          i_box_wr,
    input  logic [aim_pkg::BOX_IDX_W-1:0] i_box_idx,
    input  logic                          i_box_en,
    input  logic [aim_pkg::H_CNT_W-1:0]   i_box_x0,
    input  logic [aim_pkg::V_CNT_W-1:0]   i_box_y0,
    input  logic [aim_pkg::H_CNT_W-1:0]   i_box_x1,
    input  logic [aim_pkg::V_CNT_W-1:0]   i_box_y1,
    input  aim_pkg::pixel_t               i_box_color,
    output logic                          o_de,
    output logic                          o_hsync,
    output logic                          o_vsync,
    output aim_pkg::pixel_t               o_rgb,
    output logic                          o_underrun
);

    import aim_pkg::*;

    logic [H_CNT_W-1:0]            h_pos;
    logic [V_CNT_W-1:0]            v_pos;
    logic                          line_end;
    logic                          pop;
    logic                          de;
    logic                          hsync;
    logic                          vsync;
    logic                          frame_start;
    logic [H_CNT_W-1:0]            h_pos_d;
    logic [V_CNT_W-1:0]            v_pos_d;
    pixel_t                        fifo_pix;
    logic [N_BOX-1:0]              box_en;
    logic [N_BOX-1:0][H_CNT_W-1:0] box_x0;
    logic [N_BOX-1:0][V_CNT_W-1:0] box_y0;
    logic [N_BOX-1:0][H_CNT_W-1:0] box_x1;
    logic [N_BOX-1:0][V_CNT_W-1:0] box_y1;
    pixel_t [N_BOX-1:0]            box_color;

    raster_counter u_raster (
        .pix_clk   (pix_clk ),
        .i_arst_n  (i_arst_n),
        .o_h_pos   (h_pos   ),
        .o_v_pos   (v_pos   ),
        .o_line_end(line_end)
    );

    video_timing_fsm u_timing (
        .pix_clk      (pix_clk    ),
        .i_arst_n     (i_arst_n   ),
        .i_h_pos      (h_pos      ),
        .i_v_pos      (v_pos      ),
        .i_line_end   (line_end   ),
        .o_pop        (pop        ),
        .o_de         (de         ),
        .o_hsync      (hsync      ),
        .o_vsync      (vsync      ),
        .o_frame_start(frame_start),
        .o_h_pos      (h_pos_d    ),
        .o_v_pos      (v_pos_d    )
    );

    pixel_fifo u_fifo (
        .pix_clk    (pix_clk    ),
        .i_arst_n   (i_arst_n   ),
        .i_push     (i_pix_valid),
        .i_push_data(i_pix_data ),
        .i_pop      (pop        ),
        .o_pop_data (fifo_pix   ),
        .o_credit   (o_credit   ),
        .o_underrun (o_underrun )
    );

    box_regs u_regs (
        .pix_clk      (pix_clk    ),
        .i_arst_n     (i_arst_n   ),
        .i_box_wr     (i_box_wr   ),
        .i_box_idx    (i_box_idx  ),
        .i_box_en     (i_box_en   ),
        .i_box_x0     (i_box_x0   ),
        .i_box_y0     (i_box_y0   ),
        .i_box_x1     (i_box_x1   ),
        .i_box_y1     (i_box_y1   ),
        .i_box_color  (i_box_color),
        .i_frame_start(frame_start),
        .o_box_en     (box_en     ),
        .o_box_x0     (box_x0     ),
        .o_box_y0     (box_y0     ),
        .o_box_x1     (box_x1     ),
        .o_box_y1     (box_y1     ),
        .o_box_color  (box_color  )
    );

    box_overlay u_overlay (
        .pix_clk    (pix_clk  ),
        .i_arst_n   (i_arst_n ),
        .i_de       (de       ),
        .i_hsync    (hsync    ),
        .i_vsync    (vsync    ),
        .i_h_pos    (h_pos_d  ),
        .i_v_pos    (v_pos_d  ),
        .i_pix      (fifo_pix ),
        .i_box_en   (box_en   ),
        .i_box_x0   (box_x0   ),
        .i_box_y0   (box_y0   ),
        .i_box_x1   (box_x1   ),
        .i_box_y1   (box_y1   ),
        .i_box_color(box_color),
        .o_de       (o_de     ),
        .o_hsync    (o_hsync  ),
        .o_vsync    (o_vsync  ),
        .o_rgb      (o_rgb    )
    );

endmodule : aim_overlay_top

/* verif/tb_aim_overlay.sv */
`timescale 1ns/10ps

module tb_aim_overlay;

    import aim_pkg::*;

    localparam int CLK_NS      = 10;
    localparam int FRAME_CYC   = H_TOTAL * V_TOTAL;
    localparam int WATCHDOG_NS = 8 * FRAME_CYC * CLK_NS;
    // source goes quiet after six frames, run ends one frame later
    localparam int STOP_FRAME  = 6;
    localparam int LAST_FRAME  = 7;

    logic                 pix_clk;
    logic                 i_arst_n;
    logic                 i_pix_valid;
    pixel_t               i_pix_data;
    logic                 o_credit;
    logic                 i_box_wr;
    logic [BOX_IDX_W-1:0] i_box_idx;
    logic                 i_box_en;
    logic [H_CNT_W-1:0]   i_box_x0;
    logic [V_CNT_W-1:0]   i_box_y0;
    logic [H_CNT_W-1:0]   i_box_x1;
    logic [V_CNT_W-1:0]   i_box_y1;
    pixel_t               i_box_color;
    logic                 o_de;
    logic                 o_hsync;
    logic                 o_vsync;
    pixel_t               o_rgb;
    logic                 o_underrun;

    int unsigned lcg_state = 58;
    int          err_cnt;
    int          credits;
    int          credit_pulses;
    int          data_pops;
    int          pix_checked;
    int          frame_cnt;
    int          x;
    int          y;
    int          run_len;
    int          runs;
    int          hs_len;
    int          vs_len;
    logic        prev_de;
    logic        prev_hs;
    logic        prev_vs;
    logic        prev_credit;
    logic        prev_underrun;
    logic        seen_de;
    logic        exp_underrun;
    pixel_t      pix_q [$];
    // pushes in flight until the fifo can pop them
    logic        pend_v [3];
    pixel_t      pend_d [3];

    // model box sets
    logic   sh_en [N_BOX];
    int     sh_x0 [N_BOX];
    int     sh_y0 [N_BOX];
    int     sh_x1 [N_BOX];
    int     sh_y1 [N_BOX];
    pixel_t sh_color [N_BOX];
    logic   act_en [N_BOX];
    int     act_x0 [N_BOX];
    int     act_y0 [N_BOX];
    int     act_x1 [N_BOX];
    int     act_y1 [N_BOX];
    pixel_t act_color [N_BOX];

    aim_overlay_top uut (
        .pix_clk    (pix_clk    ),
        .i_arst_n   (i_arst_n   ),
        .i_pix_valid(i_pix_valid),
        .i_pix_data (i_pix_data ),
        .o_credit   (o_credit   ),
        .i_box_wr   (i_box_wr   ),
        .i_box_idx  (i_box_idx  ),
        .i_box_en   (i_box_en   ),
        .i_box_x0   (i_box_x0   ),
        .i_box_y0   (i_box_y0   ),
        .i_box_x1   (i_box_x1   ),
        .i_box_y1   (i_box_y1   ),
        .i_box_color(i_box_color),
        .o_de       (o_de       ),
        .o_hsync    (o_hsync    ),
        .o_vsync    (o_vsync    ),
        .o_rgb      (o_rgb      ),
        .o_underrun (o_underrun )
    );

    initial begin
        pix_clk = 1'b0;
        forever #(CLK_NS / 2) pix_clk = ~pix_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: test did not reach its last frame within %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

    function automatic int unsigned rand_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // two draws so every channel gets random bits
    function automatic pixel_t rand_pixel();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = rand_next();
        lo = rand_next();
        return {hi[7:0], lo[15:0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            err_cnt++;
            $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
        end
    endtask

    task automatic check_idle();
        check_value("o_de", 32'(o_de), 32'd0);
        check_value("o_hsync", 32'(o_hsync), 32'd0);
        check_value("o_vsync", 32'(o_vsync), 32'd0);
        check_value("o_rgb", 32'(o_rgb), 32'd0);
    endtask

    // first enabled box whose border holds the pixel sets the color
    function automatic pixel_t overlay_pixel(input pixel_t pix, input int px, input int py);
        pixel_t result;
        logic   found;
        result = pix;
        found  = 1'b0;
        for (int b = 0; b < N_BOX; b++) begin
            if (!found && act_en[b] && px >= act_x0[b] && px <= act_x1[b] &&
                py >= act_y0[b] && py <= act_y1[b] &&
                (px == act_x0[b] || px == act_x1[b] || py == act_y0[b] || py == act_y1[b])) begin
                found  = 1'b1;
                result = act_color[b];
            end
        end
        return result;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model, one call per clock
    //////////////////////////////////////////////////////////////////////

    task automatic track_timing();
        if (o_hsync) begin
            hs_len++;
        end else if (prev_hs) begin
            check_value("hsync_len", 32'(hs_len), 32'(H_SYNC));
            hs_len = 0;
        end
        if (o_vsync) begin
            vs_len++;
        end else if (prev_vs) begin
            check_value("vsync_len", 32'(vs_len), 32'(H_TOTAL * V_SYNC));
            vs_len = 0;
        end
        // new frame, boxes written last frame take over
        if (o_vsync && !prev_vs) begin
            check_value("de_runs", 32'(runs), 32'(V_ACT));
            runs = 0;
            y    = 0;
            frame_cnt++;
            act_en    = sh_en;
            act_x0    = sh_x0;
            act_y0    = sh_y0;
            act_x1    = sh_x1;
            act_y1    = sh_y1;
            act_color = sh_color;
        end
    endtask

    task automatic check_pixel();
        pixel_t base;
        logic   had_data;
        base     = '0;
        had_data = 1'b0;
        if (o_de) begin
            seen_de = 1'b1;
            if (pix_q.size() > 0) begin
                base     = pix_q.pop_front();
                had_data = 1'b1;
                data_pops++;
            end else begin
                exp_underrun = 1'b1;
            end
            check_value("o_rgb", 32'(o_rgb), 32'(overlay_pixel(base, x, y)));
            pix_checked++;
            x++;
            run_len++;
        end else begin
            if (prev_de) begin
                check_value("de_run_len", 32'(run_len), 32'(H_ACT));
                runs++;
                run_len = 0;
                x       = 0;
                y++;
            end
            check_value("o_rgb", 32'(o_rgb), 32'd0);
        end
        // credit and underrun leave the fifo one cycle ahead of the pixel
        check_value("o_credit", 32'(prev_credit), 32'(had_data));
        check_value("o_underrun", 32'(prev_underrun), 32'(exp_underrun));
    endtask

    task automatic drive_source();
        pixel_t px;
        px          = rand_pixel();
        i_pix_data  = px;
        i_pix_valid = 1'b0;
        pend_v[0]   = 1'b0;
        pend_d[0]   = px;
        if (frame_cnt < STOP_FRAME && credits > 0 && (rand_next() % 4) != 0) begin
            i_pix_valid = 1'b1;
            pend_v[0]   = 1'b1;
            credits--;
        end
    endtask

    task automatic drive_box_write();
        int idx;
        int bx0;
        int bx1;
        int by0;
        int by1;
        i_box_wr = 1'b0;
        if (o_de && frame_cnt >= 1 && (rand_next() % 12) == 0) begin
            idx = int'(rand_next() % N_BOX);
            bx0 = int'(rand_next() % H_ACT);
            bx1 = bx0 + int'(rand_next() % (H_ACT - bx0));
            by0 = int'(rand_next() % V_ACT);
            by1 = by0 + int'(rand_next() % (V_ACT - by0));
            sh_en[idx]    = (rand_next() % 4) != 0;
            sh_x0[idx]    = bx0;
            sh_x1[idx]    = bx1;
            sh_y0[idx]    = by0;
            sh_y1[idx]    = by1;
            sh_color[idx] = rand_pixel();
            i_box_wr    = 1'b1;
            i_box_idx   = BOX_IDX_W'(idx);
            i_box_en    = sh_en[idx];
            i_box_x0    = H_CNT_W'(bx0);
            i_box_x1    = H_CNT_W'(bx1);
            i_box_y0    = V_CNT_W'(by0);
            i_box_y1    = V_CNT_W'(by1);
            i_box_color = sh_color[idx];
        end
    endtask

    task automatic step_cycle();
        if (o_credit) begin
            credits++;
            credit_pulses++;
        end
        if (credits > FIFO_DEPTH) begin
            err_cnt++;
            $display("source holds more credits than the FIFO has entries at %0t", $time);
        end
        if (pend_v[2]) begin
            pix_q.push_back(pend_d[2]);
        end
        pend_v[2] = pend_v[1];
        pend_d[2] = pend_d[1];
        pend_v[1] = pend_v[0];
        pend_d[1] = pend_d[0];
        if (!seen_de && !o_de) begin
            check_idle();
        end
        track_timing();
        check_pixel();
        prev_de       = o_de;
        prev_hs       = o_hsync;
        prev_vs       = o_vsync;
        prev_credit   = o_credit;
        prev_underrun = o_underrun;
        drive_source();
        drive_box_write();
    endtask

    initial begin
        i_arst_n      = 1'b0;
        i_pix_valid   = 1'b0;
        i_pix_data    = '0;
        i_box_wr      = 1'b0;
        i_box_idx     = '0;
        i_box_en      = 1'b0;
        i_box_x0      = '0;
        i_box_y0      = '0;
        i_box_x1      = '0;
        i_box_y1      = '0;
        i_box_color   = '0;
        credits       = FIFO_DEPTH;
        exp_underrun  = 1'b0;
        seen_de       = 1'b0;
        prev_de       = 1'b0;
        prev_hs       = 1'b0;
        prev_vs       = 1'b0;
        prev_credit   = 1'b0;
        prev_underrun = 1'b0;
        for (int i = 0; i < 3; i++) begin
            pend_v[i] = 1'b0;
            pend_d[i] = '0;
        end
        for (int b = 0; b < N_BOX; b++) begin
            sh_en[b] = 1'b0;
            act_en[b] = 1'b0;
        end
        repeat (5) begin
            @(posedge pix_clk);
            #1;
            check_idle();
            check_value("o_credit", 32'(o_credit), 32'd0);
            check_value("o_underrun", 32'(o_underrun), 32'd0);
        end
        i_arst_n = 1'b1;
        while (frame_cnt < LAST_FRAME) begin
            @(posedge pix_clk);
            #1;
            step_cycle();
        end
        check_value("o_underrun", 32'(o_underrun), 32'd1);
        check_value("credit_pulses", 32'(credit_pulses), 32'(data_pops));
        check_value("source_credits", 32'(credits), 32'(FIFO_DEPTH));
        $display("pixels checked %0d, errors %0d", pix_checked, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : tb_aim_overlay

/* list.f */
hdl/aim_pkg.sv
hdl/raster_counter.sv
hdl/video_timing_fsm.sv
hdl/pixel_fifo.sv
hdl/box_regs.sv
hdl/box_overlay.sv
hdl/aim_overlay_top.sv
verif/tb_aim_overlay.sv

/* Makefile */
TOP := tb_aim_overlay

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Finished with errors" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" sim.log || (echo "simulation did not complete"; exit 1)

lint:
	verilator --lint-only -Wall --timing --top-module aim_overlay_top -f list.f

clean:
	rm -rf obj_dir sim.log
